// File: fm_core.sv
module fm_core #(
	parameter int NUM_CH = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                clk_en,
	input  logic [7:0]          din,
	input  logic [1:0]          addr,
	input  logic                cs_n,
	input  logic                wr_n,
	output logic [7:0]          dout,
	output logic                irq_n,
	output fm_types_pkg::mix_t  snd_left,
	output fm_types_pkg::mix_t  snd_right,
	output logic                snd_sample
);

	logic [7:0] timer_value;
	logic timer_run;
	logic timer_irq_en;
	logic timer_clr;
	logic flag_a;
	logic frame_tick;

	fm_voice_if voice ();
	fm_sample_if smp ();

	// One tick per frame, on the last slot
	assign frame_tick = voice.valid && voice.last;
	assign dout = {7'd0, flag_a};

	fm_reg_file #(
		.NUM_CH       ( NUM_CH       )
	) u_reg_file (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.clk_en       ( clk_en       ),
		.din          ( din          ),
		.addr         ( addr         ),
		.cs_n         ( cs_n         ),
		.wr_n         ( wr_n         ),
		.voice        ( voice        ),
		.timer_value  ( timer_value  ),
		.timer_run    ( timer_run    ),
		.timer_irq_en ( timer_irq_en ),
		.timer_clr    ( timer_clr    )
	);

	fm_timer u_timer (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.frame_tick   ( frame_tick   ),
		.timer_value  ( timer_value  ),
		.timer_run    ( timer_run    ),
		.timer_irq_en ( timer_irq_en ),
		.timer_clr    ( timer_clr    ),
		.flag_a       ( flag_a       ),
		.irq_n        ( irq_n        )
	);

	fm_tone_gen #(
		.NUM_CH ( NUM_CH )
	) u_tone_gen (
		.clk    ( clk    ),
		.rst_n  ( rst_n  ),
		.voice  ( voice  ),
		.smp    ( smp    )
	);

	fm_mixer #(
		.NUM_CH     ( NUM_CH     )
	) u_mixer (
		.clk        ( clk        ),
		.rst_n      ( rst_n      ),
		.smp        ( smp        ),
		.snd_left   ( snd_left   ),
		.snd_right  ( snd_right  ),
		.snd_sample ( snd_sample )
	);

endmodule

// File: fm_core_asserts.sv
module fm_core_asserts #(
	parameter int NUM_CH = 3
) (
	input logic                clk,
	input logic                rst_n,
	input logic                snd_sample,
	input logic                frame_tick,
	input logic                timer_clr,
	input logic                flag_a,
	input fm_types_pkg::slot_t voice_slot
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions, read by the testbench
	int fail_cnt = 0;

	// One stereo sample per frame and never a held strobe
	sample_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		snd_sample |=> !snd_sample)
		else begin
			$error("snd_sample high for two cycles in a row");
			fail_cnt++;
		end

	// Timer A overflows only on a frame tick
	flag_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(flag_a) |-> $past(frame_tick))
		else begin
			$error("flag_a set without a frame tick");
			fail_cnt++;
		end

	// Only a clear takes the flag down
	flag_hold: assert property (@(posedge clk) disable iff (!rst_n)
		flag_a && !timer_clr |=> flag_a)
		else begin
			$error("flag_a dropped without a clear");
			fail_cnt++;
		end

	slot_range: assert property (@(posedge clk) disable iff (!rst_n)
		voice_slot < NUM_CH)
		else begin
			$error("voice slot outside the channel range");
			fail_cnt++;
		end

endmodule

bind fm_core fm_core_asserts #(
	.NUM_CH     ( NUM_CH      )
) u_asserts (
	.clk        ( clk         ),
	.rst_n      ( rst_n       ),
	.snd_sample ( snd_sample  ),
	.frame_tick ( frame_tick  ),
	.timer_clr  ( timer_clr   ),
	.flag_a     ( flag_a      ),
	.voice_slot ( voice.slot  )
);

// File: fm_core_tb.sv
module fm_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Frames per test with register writes and alignment included
	localparam int RESET_FRAMES = 5;
	localparam int TONE_FRAMES = 24;
	localparam int PAN_FRAMES = 26;
	localparam int RESTART_FRAMES = 4 + TONE_FRAMES;
	localparam int TIMER_FRAMES = 13;
	localparam int TEST_FRAMES = RESET_FRAMES + TONE_FRAMES + PAN_FRAMES + RESTART_FRAMES
		+ TIMER_FRAMES;
	localparam int TIMEOUT_NS = TEST_FRAMES * 12 * 40 * 2;

	logic clk;
	logic rst_n;
	logic clk_en;
	logic [7:0] din;
	logic [1:0] addr;
	logic cs_n;
	logic wr_n;
	logic [7:0] dout;
	logic irq_n;
	fm_types_pkg::mix_t snd_left;
	fm_types_pkg::mix_t snd_right;
	logic snd_sample;
	logic [1:0] en_cnt;
	logic [15:0] lfsr;
	logic [15:0] rnd;
	fm_types_pkg::inc_t tone_inc;
	int errors;

	fm_core #(
		.NUM_CH     ( 3          )
	) u_fm_core (
		.clk        ( clk        ),
		.rst_n      ( rst_n      ),
		.clk_en     ( clk_en     ),
		.din        ( din        ),
		.addr       ( addr       ),
		.cs_n       ( cs_n       ),
		.wr_n       ( wr_n       ),
		.dout       ( dout       ),
		.irq_n      ( irq_n      ),
		.snd_left   ( snd_left   ),
		.snd_right  ( snd_right  ),
		.snd_sample ( snd_sample )
	);

	always #20 clk = ~clk;

	// One clk_en every 4 clocks once out of reset
	always @(posedge clk) begin
		if (!rst_n) begin
			#2;
			en_cnt = 2'd0;
			clk_en = 1'b0;
		end else begin
			#2;
			clk_en = (en_cnt == 2'd0);
			en_cnt = en_cnt + 2'd1;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the DUT stopped producing samples or a test never ended");
		$display("Test failed");
		$finish;
	end

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[14:0], lfsr[0]};
		end
	endtask

	// Triangle of the phase attenuated by an arithmetic shift
	function automatic int model_wave(input int ph, input int lvl);
		int p;
		int b;
		int mag;
		p = ph & 4095;
		b = (p >> 2) & 255;
		mag = ((p >> 10) & 1) ? 255 - b : b;
		if ((p >> 11) & 1)
			mag = -mag;
		return mag >>> lvl;
	endfunction

	function automatic logic [7:0] key_cmd(input int ch, input logic on);
		logic [7:0] d;
		d = 8'(ch);
		d[fm_regs_pkg::KEY_BIT] = on;
		return d;
	endfunction

	task automatic check_mix(input string name, input fm_types_pkg::mix_t exp,
		input fm_types_pkg::mix_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected dout 0x%02h, actual 0x%02h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected irq_n %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// Address write, data write, then one clock for the register to update
	task automatic write_reg(input logic [7:0] reg_num, input logic [7:0] data);
		@(posedge clk);
		#2;
		cs_n = 1'b0;
		wr_n = 1'b0;
		addr = fm_regs_pkg::PORT_ADDR;
		din = reg_num;
		@(posedge clk);
		#2;
		addr = fm_regs_pkg::PORT_DATA;
		din = data;
		@(posedge clk);
		#2;
		cs_n = 1'b1;
		wr_n = 1'b1;
		@(posedge clk);
		#2;
	endtask

	task automatic wait_sample();
		do begin
			@(posedge clk);
			#1;
		end while (!snd_sample);
	endtask

	task automatic program_ch(input int ch, input fm_types_pkg::inc_t inc,
		input fm_types_pkg::level_t lvl, input fm_types_pkg::pan_t pan);
		write_reg(fm_regs_pkg::REG_LEVEL_BASE + 8'(ch), {5'd0, lvl});
		write_reg(fm_regs_pkg::REG_FREQ_LO_BASE + 8'(ch), inc[7:0]);
		write_reg(fm_regs_pkg::REG_FREQ_HI_BASE + 8'(ch), {pan, 4'd0, inc[9:8]});
	endtask

	task automatic run_reset_check();
		check_irq("reset", 1'b1, irq_n);
		check_status("reset", 8'h00, dout);
		repeat (4) begin
			wait_sample();
			check_mix("reset_left", '0, snd_left);
			check_mix("reset_right", '0, snd_right);
		end
	endtask

	task automatic run_single_tone(input string name, input fm_types_pkg::inc_t inc);
		int tries;
		fm_types_pkg::mix_t exp;
		program_ch(0, inc, 3'd0, 2'b11);
		write_reg(fm_regs_pkg::REG_KEY, key_cmd(0, 1'b1));
		tries = 0;
		do begin
			wait_sample();
			tries++;
		end while (snd_left == 0 && tries < 6);
		if (snd_left == 0) begin
			$display("%s: no tone appeared after key on", name);
			errors++;
		end else begin
			// First nonzero sample is phase 1 x inc
			for (int k = 1; k <= 16; k++) begin
				if (k > 1)
					wait_sample();
				exp = fm_types_pkg::mix_t'(model_wave(k * int'(inc), 0));
				check_mix(name, exp, snd_left);
				check_mix(name, exp, snd_right);
			end
		end
	endtask

	task automatic run_pan_level();
		fm_types_pkg::inc_t incs [3];
		fm_types_pkg::level_t lvls [3];
		fm_types_pkg::pan_t pans [3];
		logic [15:0] r;
		int tries;
		int k;
		int w [3];
		pans[0] = 2'b10;
		pans[1] = 2'b01;
		pans[2] = 2'b11;
		for (int ch = 0; ch < 3; ch++) begin
			take_bits(10, r);
			incs[ch] = r[9:0];
			take_bits(3, r);
			lvls[ch] = r[2:0];
		end
		// Channel 2 stays audible at any level on its first step
		incs[2][9] = 1'b1;
		for (int ch = 0; ch < 3; ch++)
			write_reg(fm_regs_pkg::REG_KEY, key_cmd(ch, 1'b0));
		wait_sample();
		wait_sample();
		for (int ch = 0; ch < 3; ch++)
			program_ch(ch, incs[ch], lvls[ch], pans[ch]);
		write_reg(fm_regs_pkg::REG_KEY, key_cmd(2, 1'b1));
		tries = 0;
		do begin
			wait_sample();
			tries++;
		end while (snd_left == 0 && tries < 6);
		if (snd_left == 0) begin
			$display("pan_level: channel 2 produced no output after key on");
			errors++;
		end else begin
			// Keyed right after this sample so both start two frames later
			write_reg(fm_regs_pkg::REG_KEY, key_cmd(0, 1'b1));
			write_reg(fm_regs_pkg::REG_KEY, key_cmd(1, 1'b1));
			for (int j = 2; j <= 13; j++) begin
				wait_sample();
				k = j - 3;
				w[2] = model_wave(j * int'(incs[2]), int'(lvls[2]));
				w[0] = (k > 0) ? model_wave(k * int'(incs[0]), int'(lvls[0])) : 0;
				w[1] = (k > 0) ? model_wave(k * int'(incs[1]), int'(lvls[1])) : 0;
				check_mix("pan_level_left", fm_types_pkg::mix_t'(w[0] + w[2]), snd_left);
				check_mix("pan_level_right", fm_types_pkg::mix_t'(w[1] + w[2]), snd_right);
			end
		end
	endtask

	task automatic run_key_restart(input fm_types_pkg::inc_t inc);
		wait_sample();
		for (int ch = 0; ch < 3; ch++)
			write_reg(fm_regs_pkg::REG_KEY, key_cmd(ch, 1'b0));
		// The sample published during the writes may still carry the old keys
		repeat (2) begin
			wait_sample();
			check_mix("key_off_left", '0, snd_left);
			check_mix("key_off_right", '0, snd_right);
		end
		run_single_tone("key_restart", inc);
	endtask

	task automatic run_timer();
		int frames;
		write_reg(fm_regs_pkg::REG_TIMER_A, 8'd250);
		write_reg(fm_regs_pkg::REG_TIMER_CTRL, 8'(1 << fm_regs_pkg::RUN_BIT));
		frames = 0;
		do begin
			wait_sample();
			frames++;
			check_irq("timer_run", 1'b1, irq_n);
		end while (!dout[0] && frames < 10);
		if (frames < 5 || frames > 7) begin
			$display("[ERROR] timer_run: expected flag after 6 +/- 1 frames, actual %0d", frames);
			errors++;
		end
		write_reg(fm_regs_pkg::REG_TIMER_CTRL,
			8'((1 << fm_regs_pkg::RUN_BIT) | (1 << fm_regs_pkg::IRQ_EN_BIT)));
		check_status("timer_irq", 8'h01, dout);
		check_irq("timer_irq", 1'b0, irq_n);
		// Stop the timer with the clear so the flag cannot set again
		write_reg(fm_regs_pkg::REG_TIMER_CTRL,
			8'((1 << fm_regs_pkg::CLR_FLAG_BIT) | (1 << fm_regs_pkg::IRQ_EN_BIT)));
		@(posedge clk);
		#2;
		check_status("timer_clear", 8'h00, dout);
		check_irq("timer_clear", 1'b1, irq_n);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		clk_en = 1'b0;
		en_cnt = 2'd0;
		din = '0;
		addr = '0;
		cs_n = 1'b1;
		wr_n = 1'b1;
		errors = 0;
		lfsr = 16'd14707;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		run_reset_check();
		take_bits(10, rnd);
		tone_inc = rnd[9:0];
		if (tone_inc[9:2] == 8'd0)
			tone_inc[2] = 1'b1;
		run_single_tone("single_tone", tone_inc);
		run_pan_level();
		run_key_restart(tone_inc);
		run_timer();
		errors += u_fm_core.u_asserts.fail_cnt;
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: fm_links.sv
// Slot configuration from the register file to the tone generator
interface fm_voice_if;
	logic valid;
	fm_types_pkg::slot_t slot;
	fm_types_pkg::inc_t inc;
	fm_types_pkg::level_t level;
	fm_types_pkg::pan_t pan;
	logic key_on;
	logic last;

	modport reg_side (output valid, slot, inc, level, pan, key_on, last);
	modport gen_side (input valid, slot, inc, level, pan, key_on, last);
endinterface

// Channel samples from the tone generator to the mixer
interface fm_sample_if;
	logic valid;
	fm_types_pkg::sample_t sample;
	fm_types_pkg::pan_t pan;
	logic last;

	modport src (output valid, sample, pan, last);
	modport dst (input valid, sample, pan, last);
endinterface

// File: fm_mixer.sv
module fm_mixer #(
	parameter int NUM_CH = 3
) (
	input  logic                 clk,
	input  logic                 rst_n,
	fm_sample_if.dst             smp,
	output fm_types_pkg::mix_t   snd_left,
	output fm_types_pkg::mix_t   snd_right,
	output logic                 snd_sample
);

	// Enough headroom for NUM_CH full-scale samples
	localparam int ACC_W = $bits(fm_types_pkg::sample_t) + $clog2(NUM_CH);

	logic signed [ACC_W-1:0] ext;
	logic signed [ACC_W-1:0] add_l;
	logic signed [ACC_W-1:0] add_r;
	logic signed [ACC_W-1:0] sum_l;
	logic signed [ACC_W-1:0] sum_r;
	logic signed [ACC_W-1:0] acc_l;
	logic signed [ACC_W-1:0] acc_r;

	always_comb begin
		ext = smp.sample;
		add_l = smp.pan[1] ? ext : '0;
		add_r = smp.pan[0] ? ext : '0;
		sum_l = acc_l + add_l;
		sum_r = acc_r + add_r;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_l <= '0;
			acc_r <= '0;
			snd_left <= '0;
			snd_right <= '0;
			snd_sample <= 1'b0;
		end else begin
			snd_sample <= smp.valid && smp.last;
			if (smp.valid) begin
				if (smp.last) begin
					// Frame done, publish and start over
					snd_left <= fm_types_pkg::mix_t'(sum_l);
					snd_right <= fm_types_pkg::mix_t'(sum_r);
					acc_l <= '0;
					acc_r <= '0;
				end else begin
					acc_l <= sum_l;
					acc_r <= sum_r;
				end
			end
		end
	end

endmodule

// File: fm_reg_file.sv
module fm_reg_file #(
	parameter int NUM_CH = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                clk_en,
	input  logic [7:0]          din,
	input  logic [1:0]          addr,
	input  logic                cs_n,
	input  logic                wr_n,
	fm_voice_if.reg_side        voice,
	output logic [7:0]          timer_value,
	output logic                timer_run,
	output logic                timer_irq_en,
	output logic                timer_clr
);

	logic bus_wr;
	logic data_wr;
	logic [7:0] reg_addr;
	logic pend_we;
	logic [7:0] pend_addr;
	logic [7:0] pend_data;
	fm_types_pkg::inc_t inc_reg [NUM_CH];
	fm_types_pkg::level_t level_reg [NUM_CH];
	fm_types_pkg::pan_t pan_reg [NUM_CH];
	logic [NUM_CH-1:0] key_reg;
	logic [NUM_CH-1:0] key_lat;
	fm_types_pkg::slot_t slot_cnt;
	logic frame_start;
	logic slot_last;

	assign bus_wr = !cs_n && !wr_n;
	assign data_wr = bus_wr && (addr == fm_regs_pkg::PORT_DATA);
	assign frame_start = (slot_cnt == '0);
	assign slot_last = (slot_cnt == fm_types_pkg::slot_t'(NUM_CH - 1));

	// Address latch, data writes are applied one clock later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_addr <= '0;
			pend_we <= 1'b0;
		end else begin
			pend_we <= data_wr;
			if (bus_wr && addr == fm_regs_pkg::PORT_ADDR)
				reg_addr <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (data_wr) begin
			pend_addr <= reg_addr;
			pend_data <= din;
		end
	end

	// Register storage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_value <= '0;
			timer_run <= 1'b0;
			timer_irq_en <= 1'b0;
			timer_clr <= 1'b0;
			key_reg <= '0;
			for (int i = 0; i < NUM_CH; i++) begin
				inc_reg[i] <= '0;
				level_reg[i] <= '0;
				pan_reg[i] <= '0;
			end
		end else begin
			timer_clr <= 1'b0;
			if (pend_we) begin
				case (pend_addr)
					fm_regs_pkg::REG_TIMER_A: timer_value <= pend_data;
					fm_regs_pkg::REG_TIMER_CTRL: begin
						timer_run <= pend_data[fm_regs_pkg::RUN_BIT];
						timer_irq_en <= pend_data[fm_regs_pkg::IRQ_EN_BIT];
						timer_clr <= pend_data[fm_regs_pkg::CLR_FLAG_BIT];
					end
					fm_regs_pkg::REG_KEY: begin
						// Writes to channels beyond NUM_CH are dropped
						if (pend_data[1:0] < NUM_CH)
							key_reg[pend_data[1:0]] <= pend_data[fm_regs_pkg::KEY_BIT];
					end
					default: ;
				endcase
				for (int i = 0; i < NUM_CH; i++) begin
					if (pend_addr == 8'(fm_regs_pkg::REG_LEVEL_BASE + i))
						level_reg[i] <= pend_data[2:0];
					if (pend_addr == 8'(fm_regs_pkg::REG_FREQ_LO_BASE + i))
						inc_reg[i][7:0] <= pend_data;
					if (pend_addr == 8'(fm_regs_pkg::REG_FREQ_HI_BASE + i)) begin
						inc_reg[i][9:8] <= pend_data[1:0];
						pan_reg[i] <= pend_data[7:6];
					end
				end
			end
		end
	end

	// Slot sequencer, one slot per clk_en
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_cnt <= '0;
			key_lat <= '0;
			voice.valid <= 1'b0;
			voice.slot <= '0;
			voice.inc <= '0;
			voice.level <= '0;
			voice.pan <= '0;
			voice.key_on <= 1'b0;
			voice.last <= 1'b0;
		end else begin
			voice.valid <= clk_en;
			if (clk_en) begin
				slot_cnt <= slot_last ? '0 : slot_cnt + 1'b1;
				if (frame_start)
					key_lat <= key_reg;
				voice.slot <= slot_cnt;
				voice.inc <= inc_reg[slot_cnt];
				voice.level <= level_reg[slot_cnt];
				voice.pan <= pan_reg[slot_cnt];
				// Slot 0 sees the keys as they are latched for this frame
				voice.key_on <= frame_start ? key_reg[slot_cnt] : key_lat[slot_cnt];
				voice.last <= slot_last;
			end
		end
	end

endmodule

// File: fm_regs_pkg.sv
package fm_regs_pkg;

	// Bus ports
	localparam logic [1:0] PORT_ADDR = 2'd0;
	localparam logic [1:0] PORT_DATA = 2'd1;

	// Timer A
	localparam logic [7:0] REG_TIMER_A    = 8'h10;
	localparam logic [7:0] REG_TIMER_CTRL = 8'h11;
	localparam int RUN_BIT      = 0;
	localparam int IRQ_EN_BIT   = 2;
	localparam int CLR_FLAG_BIT = 4;

	// Key on/off, channel in data bits 1..0
	localparam logic [7:0] REG_KEY = 8'h28;
	localparam int KEY_BIT = 4;

	// Per-channel registers, base plus channel number
	localparam logic [7:0] REG_LEVEL_BASE   = 8'h40;
	localparam logic [7:0] REG_FREQ_LO_BASE = 8'hA0;
	localparam logic [7:0] REG_FREQ_HI_BASE = 8'hA4;

endpackage

// File: fm_timer.sv
module fm_timer (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       frame_tick,
	input  logic [7:0] timer_value,
	input  logic       timer_run,
	input  logic       timer_irq_en,
	input  logic       timer_clr,
	output logic       flag_a,
	output logic       irq_n
);

	logic [7:0] cnt;
	logic overflow;

	assign overflow = timer_run && frame_tick && (cnt == 8'hFF);

	// Counter holds the reload value while stopped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!timer_run) begin
			cnt <= timer_value;
		end else if (frame_tick) begin
			if (overflow)
				cnt <= timer_value;
			else
				cnt <= cnt + 8'd1;
		end
	end

	// An overflow in the same cycle as a clear keeps the flag set
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flag_a <= 1'b0;
		end else begin
			if (timer_clr)
				flag_a <= 1'b0;
			if (overflow)
				flag_a <= 1'b1;
		end
	end

	assign irq_n = !(flag_a && timer_irq_en);

endmodule

// File: fm_tone_gen.sv
module fm_tone_gen #(
	parameter int NUM_CH = 3
) (
	input  logic          clk,
	input  logic          rst_n,
	fm_voice_if.gen_side  voice,
	fm_sample_if.src      smp
);

	fm_types_pkg::phase_t phase [NUM_CH];
	fm_types_pkg::phase_t cur_phase;

	// Triangle from the phase, then attenuated by shift
	function automatic fm_types_pkg::sample_t wave(
		input fm_types_pkg::phase_t ph,
		input fm_types_pkg::level_t lvl
	);
		logic [7:0] b;
		logic [7:0] mag;
		fm_types_pkg::sample_t raw;
		b = ph[9:2];
		// Falling slope in the second quarter of each half
		mag = ph[10] ? 8'd255 - b : b;
		raw = {1'b0, mag};
		if (ph[11])
			raw = -raw;
		return raw >>> lvl;
	endfunction

	assign cur_phase = phase[voice.slot];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_CH; i++)
				phase[i] <= '0;
			smp.valid <= 1'b0;
			smp.sample <= '0;
			smp.pan <= '0;
			smp.last <= 1'b0;
		end else begin
			smp.valid <= voice.valid;
			if (voice.valid) begin
				smp.sample <= voice.key_on ? wave(cur_phase, voice.level) : '0;
				smp.pan <= voice.pan;
				smp.last <= voice.last;
				// Output uses the old phase, the step comes after
				phase[voice.slot] <= voice.key_on ? cur_phase + voice.inc : '0;
			end
		end
	end

endmodule

// File: fm_types_pkg.sv
package fm_types_pkg;

	// Phase of one channel, bit 11 is the sign half and bit 10 the slope
	typedef logic [11:0] phase_t;

	// Phase step added once per frame
	typedef logic [9:0] inc_t;

	// Attenuation as a right-shift amount
	typedef logic [2:0] level_t;

	// Waveform output of one channel
	typedef logic signed [8:0] sample_t;

	// Left or right output sample
	typedef logic signed [11:0] mix_t;

	// Channel slot index within a frame
	typedef logic [1:0] slot_t;

	// Bit 1 left, bit 0 right
	typedef logic [1:0] pan_t;

endpackage

// File: project.f
fm_types_pkg.sv
fm_regs_pkg.sv
fm_links.sv
fm_reg_file.sv
fm_timer.sv
fm_tone_gen.sv
fm_mixer.sv
fm_core.sv
fm_core_asserts.sv
fm_core_tb.sv
